// ==== Bender.yml ====
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/cache_array_if.sv
  - source/miss_if.sv
  - source/cache_arrays.sv
  - source/store_merge.sv
  - source/lookup_pipe.sv
  - source/miss_ctrl.sv
  - source/dcache.sv
  - target: simulation
    files:
      - bench/tb_dcache.sv

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int WAIT_LIMIT = 500;
    localparam int MEM_DELAY = 3;

    typedef struct packed {
        logic we;
        logic must_hit;
        addr_t addr;
        word_t data;
        logic [31:0] cycle;
    } resp_t;

    logic clk;
    logic rst;
    logic req_valid;
    addr_t req_addr;
    logic req_we;
    strb_t req_strb;
    word_t req_wdata;
    logic ready;
    logic data_ok;
    word_t rdata;
    logic mem_req;
    logic mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    logic mem_wdone;
    logic mem_rvalid;
    line_t mem_rdata;

    int error_count;
    int check_count;
    int cycle;
    resp_t exp_q[$];
    word_t shadow[addr_t];
    line_t mem_lines[addr_t];

    // open memory request
    logic pend_valid;
    logic pend_we;
    addr_t pend_addr;
    int pend_cnt;
    int fetch_count;
    int write_count;
    addr_t last_fetch_addr;
    addr_t last_write_addr;

    dcache DUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_addr_i  (req_addr),
        .req_we_i    (req_we),
        .req_strb_i  (req_strb),
        .req_wdata_i (req_wdata),
        .ready_o     (ready),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_wdone_i (mem_wdone),
        .mem_rvalid_i(mem_rvalid),
        .mem_rdata_i (mem_rdata)
    );

    always begin
        #20 clk = ~clk;
    end

    // every address bit feeds the fill pattern
    function automatic word_t init_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
    endfunction

    function automatic word_t shadow_word(addr_t a);
        addr_t wa;
        wa = {a[ADDR_W-1:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return init_word(wa);
    endfunction

    function automatic line_t shadow_line(addr_t la);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w * WORD_W +: WORD_W] = shadow_word(addr_t'(la + 4 * w));
        end
        return l;
    endfunction

    function automatic line_t mem_line(addr_t la);
        line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w * WORD_W +: WORD_W] = init_word(addr_t'(la + 4 * w));
        end
        return l;
    endfunction

    task automatic finish_run();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        error_count++;
        $display("timed out waiting for %s", what);
        finish_run();
    endtask

    // drive one request once ready_o is high and log the expected answer
    task automatic send(input logic we, input addr_t addr, input strb_t strb,
                        input word_t wdata, input logic must_hit);
        resp_t r;
        word_t w;
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ready) begin
            req_valid = 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeout_abort("ready_o");
            end
            @(negedge clk);
        end
        req_valid = 1'b1;
        req_addr = addr;
        req_we = we;
        req_strb = strb;
        req_wdata = wdata;
        r.we = we;
        r.must_hit = must_hit;
        r.addr = addr;
        r.data = shadow_word(addr);
        r.cycle = cycle;
        exp_q.push_back(r);
        if (we) begin
            w = shadow_word(addr);
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) begin
                    w[b * 8 +: 8] = wdata[b * 8 +: 8];
                end
            end
            shadow[{addr[ADDR_W-1:2], 2'b00}] = w;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeout_abort("data_ok_o");
            end
            @(negedge clk);
        end
    endtask

    // responses and memory requests are sampled before the edge updates them
    always @(posedge clk) begin
        resp_t r;
        if (!rst) begin
            if (data_ok) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("data_ok_o raised with no request outstanding");
                end else begin
                    r = exp_q.pop_front();
                    check_count++;
                    if (!r.we && rdata !== r.data) begin
                        error_count++;
                        $display("[FAIL] rdata_o addr %h: got %h expected %h",
                                 r.addr, rdata, r.data);
                    end
                    if (r.must_hit && cycle != r.cycle + 1) begin
                        error_count++;
                        $display("hit at %h took %0d cycles instead of one",
                                 r.addr, cycle - r.cycle);
                    end
                end
            end
            if (mem_req) begin
                check_count++;
                if (pend_valid || mem_addr[OFFSET_W-1:0] != '0) begin
                    error_count++;
                    $display("memory request overlapped another or was not line aligned");
                end
                pend_valid = 1'b1;
                pend_we = mem_we;
                pend_addr = mem_addr;
                pend_cnt = MEM_DELAY;
                if (mem_we) begin
                    write_count++;
                    last_write_addr = mem_addr;
                    if (mem_wdata !== shadow_line(mem_addr)) begin
                        error_count++;
                        $display("[FAIL] mem_wdata_o addr %h: got %h expected %h",
                                 mem_addr, mem_wdata, shadow_line(mem_addr));
                    end
                    mem_lines[mem_addr] = mem_wdata;
                end else begin
                    fetch_count++;
                    last_fetch_addr = mem_addr;
                end
            end
        end
        cycle++;
    end

    always @(negedge clk) begin
        mem_wdone = 1'b0;
        mem_rvalid = 1'b0;
        if (pend_valid) begin
            pend_cnt--;
            if (pend_cnt == 0) begin
                pend_valid = 1'b0;
                if (pend_we) begin
                    mem_wdone = 1'b1;
                end else begin
                    mem_rvalid = 1'b1;
                    mem_rdata = mem_line(pend_addr);
                end
            end
        end
    end

    task automatic test_load_miss();
        int f0;
        int w0;
        f0 = fetch_count;
        w0 = write_count;
        send(1'b0, 32'h0000_1234, '0, '0, 1'b0);
        drain();
        check_count++;
        if (fetch_count != f0 + 1 || write_count != w0) begin
            error_count++;
            $display("cold load miss made %0d fetches and %0d writes instead of one fetch",
                     fetch_count - f0, write_count - w0);
        end
        check_count++;
        if (last_fetch_addr !== 32'h0000_1230) begin
            error_count++;
            $display("[FAIL] mem_addr_o: got %h expected %h", last_fetch_addr, 32'h0000_1230);
        end
    endtask

    task automatic test_hit_burst();
        int f0;
        int w0;
        f0 = fetch_count;
        w0 = write_count;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            send(1'b0, addr_t'(32'h0000_1230 + 4 * i), '0, '0, 1'b1);
        end
        drain();
        check_count++;
        if (fetch_count != f0 || write_count != w0) begin
            error_count++;
            $display("loads to a cached line went to memory");
        end
    endtask

    // each store is followed at once by a load of the same set
    task automatic test_store_hits();
        send(1'b1, 32'h0000_1231, 4'b0010, 32'h0000_a500, 1'b1);
        send(1'b0, 32'h0000_1230, '0, '0, 1'b1);
        send(1'b1, 32'h0000_1236, 4'b1100, 32'hbeef_0000, 1'b1);
        send(1'b0, 32'h0000_1234, '0, '0, 1'b1);
        send(1'b1, 32'h0000_1238, 4'b1111, 32'hcafe_f00d, 1'b1);
        send(1'b0, 32'h0000_1238, '0, '0, 1'b1);
        send(1'b0, 32'h0000_1230, '0, '0, 1'b1);
        drain();
    endtask

    task automatic test_dirty_evict();
        int w0;
        send(1'b1, 32'h0001_0400, 4'b1111, 32'h1111_aaaa, 1'b0);
        send(1'b1, 32'h0002_0404, 4'b0011, 32'h0000_5555, 1'b0);
        drain();
        w0 = write_count;
        send(1'b0, 32'h0003_0408, '0, '0, 1'b0);
        drain();
        check_count++;
        if (write_count != w0 + 1) begin
            error_count++;
            $display("third line in a full dirty set made %0d memory writes",
                     write_count - w0);
        end else if (last_write_addr !== 32'h0001_0400
                     && last_write_addr !== 32'h0002_0400) begin
            error_count++;
            $display("[FAIL] mem_addr_o: got %h expected %h or %h",
                     last_write_addr, 32'h0001_0400, 32'h0002_0400);
        end
        send(1'b0, 32'h0001_0400, '0, '0, 1'b0);
        send(1'b0, 32'h0002_0404, '0, '0, 1'b0);
        drain();
    endtask

    // four tags in each of two sets keep the victims moving
    task automatic test_random();
        addr_t pool [0:7];
        int idx;
        for (int i = 0; i < 8; i++) begin
            pool[i] = addr_t'(((256 + i / 2) << 12) + ((128 + i % 2) << 4)
                              + (((i * 3) % 4) << 2));
        end
        for (int n = 0; n < 200; n++) begin
            idx = $urandom_range(7, 0);
            if ($urandom_range(1, 0) == 1) begin
                send(1'b1, pool[idx], strb_t'($urandom_range(15, 1)), $urandom, 1'b0);
            end else begin
                send(1'b0, pool[idx], '0, '0, 1'b0);
            end
        end
        drain();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_we = 1'b0;
        req_strb = '0;
        req_wdata = '0;
        mem_wdone = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        pend_valid = 1'b0;
        pend_we = 1'b0;
        pend_addr = '0;
        pend_cnt = 0;
        void'($urandom(97));
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_count++;
        if (ready !== 1'b1 || data_ok !== 1'b0 || mem_req !== 1'b0) begin
            error_count++;
            $display("outputs not idle after reset");
        end
        test_load_miss();
        test_hit_burst();
        test_store_hits();
        test_dirty_evict();
        test_random();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/dcache_pkg.sv
source/cache_array_if.sv
source/miss_if.sv
source/cache_arrays.sv
source/store_merge.sv
source/lookup_pipe.sv
source/miss_ctrl.sv
source/dcache.sv
bench/tb_dcache.sv

// ==== source/cache_array_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface cache_array_if;
    import dcache_pkg::*;

    // read port with data valid the cycle after rd_en
    logic rd_en;
    index_t rd_index;
    tag_entry_t [NWAY-1:0] rd_entry;
    line_t [NWAY-1:0] rd_line;

    // write port with one index shared by both ways
    logic [NWAY-1:0] wr_en;
    index_t wr_index;
    tag_entry_t wr_entry;
    line_t wr_line;

    modport pipe (
        output rd_en, rd_index, wr_en, wr_index, wr_entry, wr_line,
        input  rd_entry, rd_line
    );

    modport arrays (
        input  rd_en, rd_index, wr_en, wr_index, wr_entry, wr_line,
        output rd_entry, rd_line
    );

endinterface

`default_nettype wire

// ==== source/cache_arrays.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_arrays (
    input wire clk,
    input wire rst,
    cache_array_if.arrays arr_if
);
    import dcache_pkg::*;

    tag_entry_t tag_mem [NWAY][NSET];
    line_t line_mem [NWAY][NSET];

    // clear valid and dirty of every set while in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NWAY; w++) begin
                for (int s = 0; s < NSET; s++) begin
                    tag_mem[w][s].valid <= 1'b0;
                    tag_mem[w][s].dirty <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < NWAY; w++) begin
                if (arr_if.wr_en[w]) begin
                    tag_mem[w][arr_if.wr_index] <= arr_if.wr_entry;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NWAY; w++) begin
            if (arr_if.wr_en[w]) begin
                line_mem[w][arr_if.wr_index] <= arr_if.wr_line;
            end
        end
    end

    // reads return the old contents and the pipe forwards a colliding write
    always_ff @(posedge clk) begin
        if (arr_if.rd_en) begin
            for (int w = 0; w < NWAY; w++) begin
                arr_if.rd_entry[w] <= tag_mem[w][arr_if.rd_index];
                arr_if.rd_line[w] <= line_mem[w][arr_if.rd_index];
            end
        end
    end

    a_one_way_written: assert property (
        @(posedge clk) disable iff (rst) $onehot0(arr_if.wr_en)
    );

endmodule

`default_nettype wire

// ==== source/dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  wire clk,
    input  wire rst,

    // load/store unit
    input  wire req_valid_i,
    input  wire dcache_pkg::addr_t req_addr_i,
    input  wire req_we_i,
    input  wire dcache_pkg::strb_t req_strb_i,
    input  wire dcache_pkg::word_t req_wdata_i,
    output logic ready_o,
    output logic data_ok_o,
    output dcache_pkg::word_t rdata_o,

    // line-wide memory port
    output logic mem_req_o,
    output logic mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input  wire mem_wdone_i,
    input  wire mem_rvalid_i,
    input  wire dcache_pkg::line_t mem_rdata_i
);

    cache_array_if u_arr_if ();
    miss_if u_mis_if ();

    cache_arrays u_arrays (
        .clk   (clk),
        .rst   (rst),
        .arr_if(u_arr_if.arrays)
    );

    lookup_pipe u_lookup (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid_i),
        .req_addr_i (req_addr_i),
        .req_we_i   (req_we_i),
        .req_strb_i (req_strb_i),
        .req_wdata_i(req_wdata_i),
        .ready_o    (ready_o),
        .data_ok_o  (data_ok_o),
        .rdata_o    (rdata_o),
        .arr_if     (u_arr_if.pipe),
        .mis_if     (u_mis_if.pipe)
    );

    miss_ctrl u_miss (
        .clk         (clk),
        .rst         (rst),
        .mis_if      (u_mis_if.ctrl),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wdone_i (mem_wdone_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W = 8;
    localparam int NSET = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NWAY = 2;
    localparam int STRB_W = WORD_W / 8;

    // replacement lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hace1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] woff_t;
    typedef logic [$clog2(NWAY)-1:0] way_t;

    // 22 bits as stored in the tag ram
    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_WB_REQ,
        MS_WB_WAIT,
        MS_FETCH_REQ,
        MS_FETCH_WAIT
    } miss_state_e;

endpackage

`default_nettype wire

// ==== source/lookup_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module lookup_pipe (
    input  wire clk,
    input  wire rst,
    input  wire req_valid_i,
    input  wire dcache_pkg::addr_t req_addr_i,
    input  wire req_we_i,
    input  wire dcache_pkg::strb_t req_strb_i,
    input  wire dcache_pkg::word_t req_wdata_i,
    output logic ready_o,
    output logic data_ok_o,
    output dcache_pkg::word_t rdata_o,
    cache_array_if.pipe arr_if,
    miss_if.pipe mis_if
);
    import dcache_pkg::*;

    logic accept;

    // stage 2 request
    logic s2_valid;
    tag_t s2_tag;
    index_t s2_index;
    woff_t s2_woff;
    logic s2_we;
    strb_t s2_strb;
    word_t s2_wdata;

    logic [NWAY-1:0] fwd_en;
    tag_entry_t fwd_entry;
    line_t fwd_line;
    tag_entry_t [NWAY-1:0] view_entry;
    line_t [NWAY-1:0] view_line;

    logic [NWAY-1:0] hit_way;
    logic hit;
    way_t hit_sel;
    line_t hit_line;
    line_t hit_merged;
    line_t refill_merged;
    line_t resp_line;

    logic [LFSR_W-1:0] lfsr;
    way_t victim;
    way_t victim_q;
    logic miss_sent;

    // stage 1 sends the array read with the accepted request
    assign accept = req_valid_i && ready_o;
    assign arr_if.rd_en = accept;
    assign arr_if.rd_index = req_addr_i[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (ready_o || mis_if.refill_valid) begin
            s2_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_tag <= req_addr_i[ADDR_W-1 -: TAG_W];
            s2_index <= req_addr_i[OFFSET_W +: INDEX_W];
            s2_woff <= req_addr_i[OFFSET_W-1 -: $bits(woff_t)];
            s2_we <= req_we_i;
            s2_strb <= req_strb_i;
            s2_wdata <= req_wdata_i;
        end
    end

    // a write at the read edge is not seen by the arrays output
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_en <= '0;
        end else if (accept) begin
            for (int w = 0; w < NWAY; w++) begin
                fwd_en[w] <= arr_if.wr_en[w] && (arr_if.wr_index == arr_if.rd_index);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fwd_entry <= arr_if.wr_entry;
            fwd_line <= arr_if.wr_line;
        end
    end

    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            view_entry[w] = fwd_en[w] ? fwd_entry : arr_if.rd_entry[w];
            view_line[w] = fwd_en[w] ? fwd_line : arr_if.rd_line[w];
            hit_way[w] = s2_valid && view_entry[w].valid && (view_entry[w].tag == s2_tag);
        end
    end

    always_comb begin
        hit_sel = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (hit_way[w]) begin
                hit_sel = way_t'(w);
            end
        end
    end

    assign hit = |hit_way;
    assign hit_line = view_line[hit_sel];

    store_merge u_hit_merge (
        .line_i (hit_line),
        .woff_i (s2_woff),
        .strb_i (s2_strb),
        .wdata_i(s2_wdata),
        .line_o (hit_merged)
    );

    store_merge u_refill_merge (
        .line_i (mis_if.refill_line),
        .woff_i (s2_woff),
        .strb_i (s2_strb),
        .wdata_i(s2_wdata),
        .line_o (refill_merged)
    );

    // refill writes the victim way and a store hit writes the hit way
    always_comb begin
        arr_if.wr_en = '0;
        arr_if.wr_index = s2_index;
        arr_if.wr_entry = '{dirty: 1'b1, valid: 1'b1, tag: s2_tag};
        arr_if.wr_line = hit_merged;
        if (mis_if.refill_valid) begin
            arr_if.wr_en[victim_q] = 1'b1;
            arr_if.wr_entry.dirty = s2_we;
            arr_if.wr_line = s2_we ? refill_merged : mis_if.refill_line;
        end else if (hit && s2_we) begin
            arr_if.wr_en[hit_sel] = 1'b1;
        end
    end

    assign ready_o = !(s2_valid && !hit);
    assign data_ok_o = s2_valid && (hit || mis_if.refill_valid);
    assign resp_line = hit ? hit_line : mis_if.refill_line;
    assign rdata_o = resp_line[s2_woff * WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // an empty way wins over the random pick
    always_comb begin
        victim = way_t'(lfsr);
        for (int w = NWAY - 1; w >= 0; w--) begin
            if (!view_entry[w].valid) begin
                victim = way_t'(w);
            end
        end
    end

    assign mis_if.miss_valid = s2_valid && !hit && !miss_sent;
    assign mis_if.miss_addr = {s2_tag, s2_index, {OFFSET_W{1'b0}}};
    assign mis_if.victim_dirty = view_entry[victim].valid && view_entry[victim].dirty;
    assign mis_if.victim_addr = {view_entry[victim].tag, s2_index, {OFFSET_W{1'b0}}};
    assign mis_if.victim_line = view_line[victim];

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_sent <= 1'b0;
        end else if (mis_if.refill_valid) begin
            miss_sent <= 1'b0;
        end else if (mis_if.miss_valid) begin
            miss_sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mis_if.miss_valid) begin
            victim_q <= victim;
        end
    end

    a_req_only_when_ready: assert property (
        @(posedge clk) disable iff (rst) req_valid_i |-> ready_o
    );

endmodule

`default_nettype wire

// ==== source/miss_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_ctrl (
    input  wire clk,
    input  wire rst,
    miss_if.ctrl mis_if,
    output logic mem_req_o,
    output logic mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input  wire mem_wdone_i,
    input  wire mem_rvalid_i,
    input  wire dcache_pkg::line_t mem_rdata_i
);
    import dcache_pkg::*;

    miss_state_e state_q;
    miss_state_e state_d;

    addr_t miss_addr_q;
    addr_t victim_addr_q;
    line_t victim_line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                if (mis_if.miss_valid) begin
                    state_d = mis_if.victim_dirty ? MS_WB_REQ : MS_FETCH_REQ;
                end
            end
            MS_WB_REQ: begin
                state_d = MS_WB_WAIT;
            end
            MS_WB_WAIT: begin
                if (mem_wdone_i) begin
                    state_d = MS_FETCH_REQ;
                end
            end
            MS_FETCH_REQ: begin
                state_d = MS_FETCH_WAIT;
            end
            MS_FETCH_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = MS_IDLE;
                end
            end
            default: begin
                state_d = MS_IDLE;
            end
        endcase
    end

    // keep the miss and the victim for the whole sequence
    always_ff @(posedge clk) begin
        if (state_q == MS_IDLE && mis_if.miss_valid) begin
            miss_addr_q <= mis_if.miss_addr;
            victim_addr_q <= mis_if.victim_addr;
            victim_line_q <= mis_if.victim_line;
        end
    end

    // one-cycle request strobes
    assign mem_req_o = (state_q == MS_WB_REQ) || (state_q == MS_FETCH_REQ);
    assign mem_we_o = (state_q == MS_WB_REQ);
    assign mem_addr_o = mem_we_o ? victim_addr_q : miss_addr_q;
    assign mem_wdata_o = victim_line_q;

    assign mis_if.refill_valid = (state_q == MS_FETCH_WAIT) && mem_rvalid_i;
    assign mis_if.refill_line = mem_rdata_i;

    a_rvalid_in_fetch_wait: assert property (
        @(posedge clk) disable iff (rst) mem_rvalid_i |-> state_q == MS_FETCH_WAIT
    );

    a_wdone_in_wb_wait: assert property (
        @(posedge clk) disable iff (rst) mem_wdone_i |-> state_q == MS_WB_WAIT
    );

endmodule

`default_nettype wire

// ==== source/miss_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface miss_if;
    import dcache_pkg::*;

    // miss request with the chosen victim
    logic miss_valid;
    addr_t miss_addr;
    logic victim_dirty;
    addr_t victim_addr;
    line_t victim_line;

    // refill answer
    logic refill_valid;
    line_t refill_line;

    modport pipe (
        output miss_valid, miss_addr, victim_dirty, victim_addr, victim_line,
        input  refill_valid, refill_line
    );

    modport ctrl (
        input  miss_valid, miss_addr, victim_dirty, victim_addr, victim_line,
        output refill_valid, refill_line
    );

endinterface

`default_nettype wire

// ==== source/store_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module store_merge (
    input  wire dcache_pkg::line_t line_i,
    input  wire dcache_pkg::woff_t woff_i,
    input  wire dcache_pkg::strb_t strb_i,
    input  wire dcache_pkg::word_t wdata_i,
    output dcache_pkg::line_t line_o
);
    import dcache_pkg::*;

    // byte lanes outside the strobe keep the old line
    always_comb begin
        line_o = line_i;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb_i[b]) begin
                line_o[woff_i * WORD_W + b * 8 +: 8] = wdata_i[b * 8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire
